//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = exec_int_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- build.f
+incdir+verification
hdl/riscv_isa_pkg.sv
hdl/exec_pkg.sv
hdl/int_decode.sv
hdl/int_alu.sv
hdl/int_multiplier.sv
hdl/int_writeback.sv
hdl/exec_int_unit.sv
verification/exec_int_tb.sv

//--- hdl/exec_int_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_int_unit
    import riscv_isa_pkg::*;
    import exec_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        i_valid,
    input  wire exec_issue_t i_issue,
    output logic             o_valid,
    output exec_result_t     o_result
);

    decoded_op_t       s1_op;
    exec_result_t      s2_alu;
    logic              s2_valid;
    logic              s2_is_mul;
    mul_op_t           s2_mul_op;
    logic [2*XLEN-1:0] s2_product;

    int_decode u_decode (
        .clk     (clk),
        .rst     (rst),
        .i_valid (i_valid),
        .i_issue (i_issue),
        .o_op    (s1_op)
    );

    int_alu u_alu (
        .clk      (clk),
        .rst      (rst),
        .i_op     (s1_op),
        .o_result (s2_alu),
        .o_valid  (s2_valid),
        .o_is_mul (s2_is_mul),
        .o_mul_op (s2_mul_op)
    );

    int_multiplier u_multiplier (
        .clk       (clk),
        .i_op      (s1_op),
        .o_product (s2_product)
    );

    int_writeback u_writeback (
        .i_valid   (s2_valid),
        .i_alu     (s2_alu),
        .i_is_mul  (s2_is_mul),
        .i_mul_op  (s2_mul_op),
        .i_product (s2_product),
        .o_valid   (o_valid),
        .o_result  (o_result)
    );

endmodule

`default_nettype wire

//--- hdl/exec_pkg.sv
`default_nettype none

package exec_pkg;

    import riscv_isa_pkg::*;

    typedef struct packed {
        opcode_t opcode;
        funct3_t funct3;
        funct7_t funct7;
        xlen_t   rs1;
        xlen_t   rs2;
        imm_i_t  imm_i;
        imm_u_t  imm_u;
    } exec_issue_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_LUI
    } alu_op_t;

    typedef enum logic [1:0] {
        MUL_LO,   // Low half, sign does not matter
        MUL_HSS,
        MUL_HSU,
        MUL_HUU
    } mul_op_t;

    typedef struct packed {
        logic    valid;
        logic    is_mul;
        logic    illegal;
        alu_op_t alu_op;
        mul_op_t mul_op;
        xlen_t   opa;
        xlen_t   opb;     // rs2 or extended immediate
    } decoded_op_t;

    typedef struct packed {
        logic   exception;
        cause_t cause;
        xlen_t  value;
    } exec_result_t;

endpackage

`default_nettype wire

//--- hdl/int_alu.sv
`timescale 1ns/1ps
`default_nettype none

module int_alu
    import riscv_isa_pkg::*;
    import exec_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire decoded_op_t i_op,
    output exec_result_t     o_result,
    output logic             o_valid,
    output logic             o_is_mul,
    output mul_op_t          o_mul_op
);

    logic [SHAMT_W-1:0] shamt;
    xlen_t              alu_value;

    assign shamt = i_op.opb[SHAMT_W-1:0];

    always_comb begin
        case (i_op.alu_op)
            ALU_ADD:  alu_value = i_op.opa + i_op.opb;
            ALU_SUB:  alu_value = i_op.opa - i_op.opb;
            ALU_SLL:  alu_value = i_op.opa << shamt;
            ALU_SLT:  alu_value = xlen_t'($signed(i_op.opa) < $signed(i_op.opb));
            ALU_SLTU: alu_value = xlen_t'(i_op.opa < i_op.opb);
            ALU_XOR:  alu_value = i_op.opa ^ i_op.opb;
            ALU_SRL:  alu_value = i_op.opa >> shamt;
            ALU_SRA:  alu_value = xlen_t'($signed(i_op.opa) >>> shamt);
            ALU_OR:   alu_value = i_op.opa | i_op.opb;
            ALU_AND:  alu_value = i_op.opa & i_op.opb;
            ALU_LUI:  alu_value = i_op.opb << 12;  // opb holds sign-extended U imm
            default:  alu_value = '0;
        endcase
        if (i_op.illegal) begin
            alu_value = '0;
        end
    end

    always_ff @(posedge clk) begin
        o_result.value <= alu_value;
        o_result.cause <= i_op.illegal ? CAUSE_ILLEGAL_INSTR : cause_t'(0);
        o_is_mul       <= i_op.is_mul;
        o_mul_op       <= i_op.mul_op;
        if (rst) begin
            o_valid            <= 1'b0;
            o_result.exception <= 1'b0;
        end else begin
            o_valid            <= i_op.valid;
            o_result.exception <= i_op.valid && i_op.illegal;
        end
    end

endmodule

`default_nettype wire

//--- hdl/int_decode.sv
`timescale 1ns/1ps
`default_nettype none

module int_decode
    import riscv_isa_pkg::*;
    import exec_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        i_valid,
    input  wire exec_issue_t i_issue,
    output decoded_op_t      o_op
);

    // funct3 encoding shared by OP and OP_IMM
    function automatic alu_op_t base_alu_op(input funct3_t f3);
        case (f3)
            3'b000:  return ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    decoded_op_t dec_op;
    xlen_t       imm_i_ext;
    xlen_t       imm_u_ext;

    assign imm_i_ext = {{(XLEN-12){i_issue.imm_i[11]}}, i_issue.imm_i};
    assign imm_u_ext = {{(XLEN-20){i_issue.imm_u[19]}}, i_issue.imm_u};

    always_comb begin
        dec_op         = '0;
        dec_op.valid   = i_valid;
        dec_op.alu_op  = base_alu_op(i_issue.funct3);
        dec_op.mul_op  = MUL_LO;
        dec_op.opa     = i_issue.rs1;
        dec_op.opb     = i_issue.rs2;
        case (i_issue.opcode)
            OPC_LUI: begin
                dec_op.alu_op = ALU_LUI;
                dec_op.opb    = imm_u_ext;
            end
            OPC_OP_IMM: begin
                dec_op.opb = imm_i_ext;
                if (i_issue.funct3 == 3'b001) begin
                    dec_op.illegal = i_issue.imm_i[11:6] != '0;
                end else if (i_issue.funct3 == 3'b101) begin
                    if (i_issue.imm_i[11:6] == 6'b010000) begin
                        dec_op.alu_op = ALU_SRA;  // SRAI
                    end else begin
                        dec_op.illegal = i_issue.imm_i[11:6] != '0;
                    end
                end
            end
            OPC_OP: begin
                if (i_issue.funct7 == FUNCT7_ALT) begin
                    if (i_issue.funct3 == 3'b000) begin
                        dec_op.alu_op = ALU_SUB;
                    end else if (i_issue.funct3 == 3'b101) begin
                        dec_op.alu_op = ALU_SRA;
                    end else begin
                        dec_op.illegal = 1'b1;
                    end
                end else if (i_issue.funct7 == FUNCT7_MULDIV) begin
                    dec_op.is_mul  = !i_issue.funct3[2];
                    dec_op.illegal = i_issue.funct3[2];  // No divider
                    case (i_issue.funct3[1:0])
                        2'b00:   dec_op.mul_op = MUL_LO;
                        2'b01:   dec_op.mul_op = MUL_HSS;
                        2'b10:   dec_op.mul_op = MUL_HSU;
                        default: dec_op.mul_op = MUL_HUU;
                    endcase
                end else if (i_issue.funct7 != FUNCT7_BASE) begin
                    dec_op.illegal = 1'b1;
                end
            end
            default: dec_op.illegal = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        o_op <= dec_op;
        if (rst) begin
            o_op.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/int_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module int_multiplier
    import riscv_isa_pkg::*;
    import exec_pkg::*;
(
    input  wire logic          clk,
    input  wire decoded_op_t   i_op,
    output logic [2*XLEN-1:0]  o_product
);

    half_t a_hi;
    half_t a_lo;
    half_t b_hi;
    half_t b_lo;
    logic  a_signed;
    logic  b_signed;
    xlen_t pp_hh;
    xlen_t pp_hl;
    xlen_t pp_lh;
    xlen_t pp_ll;
    xlen_t corr;
    logic [2*XLEN-1:0] raw_sum;

    assign a_hi = i_op.opa[XLEN-1:HALF_W];
    assign a_lo = i_op.opa[HALF_W-1:0];
    assign b_hi = i_op.opb[XLEN-1:HALF_W];
    assign b_lo = i_op.opb[HALF_W-1:0];

    assign a_signed = (i_op.mul_op == MUL_HSS) || (i_op.mul_op == MUL_HSU);
    assign b_signed = (i_op.mul_op == MUL_HSS);

    always_ff @(posedge clk) begin
        if (i_op.valid && i_op.is_mul) begin
            pp_hh <= a_hi * b_hi;
            pp_hl <= a_hi * b_lo;
            pp_lh <= a_lo * b_hi;
            pp_ll <= a_lo * b_lo;
            // Unsigned product minus 2^64 times the other operand per negative signed input
            corr  <= ((a_signed && i_op.opa[XLEN-1]) ? -i_op.opb : xlen_t'(0))
                   + ((b_signed && i_op.opb[XLEN-1]) ? -i_op.opa : xlen_t'(0));
        end
    end

    assign raw_sum = {{XLEN{1'b0}}, pp_ll}
                   + {{HALF_W{1'b0}}, pp_hl, {HALF_W{1'b0}}}
                   + {{HALF_W{1'b0}}, pp_lh, {HALF_W{1'b0}}}
                   + {pp_hh, {XLEN{1'b0}}};

    assign o_product = {raw_sum[2*XLEN-1:XLEN] + corr, raw_sum[XLEN-1:0]};

endmodule

`default_nettype wire

//--- hdl/int_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module int_writeback
    import riscv_isa_pkg::*;
    import exec_pkg::*;
(
    input  wire logic              i_valid,
    input  wire exec_result_t      i_alu,
    input  wire logic              i_is_mul,
    input  wire mul_op_t           i_mul_op,
    input  wire logic [2*XLEN-1:0] i_product,
    output logic                   o_valid,
    output exec_result_t           o_result
);

    xlen_t mul_value;

    // MUL keeps the low word, the MULH variants the high word
    assign mul_value = (i_mul_op == MUL_LO) ? i_product[XLEN-1:0]
                                            : i_product[2*XLEN-1:XLEN];

    always_comb begin
        o_result = i_alu;
        if (i_is_mul) begin
            o_result.value = mul_value;
        end
    end

    assign o_valid = i_valid;

endmodule

`default_nettype wire

//--- hdl/riscv_isa_pkg.sv
`default_nettype none

package riscv_isa_pkg;

    localparam int XLEN    = 64;
    localparam int HALF_W  = 32;
    localparam int SHAMT_W = 6;

    typedef logic [XLEN-1:0]   xlen_t;
    typedef logic [HALF_W-1:0] half_t;

    typedef logic [4:0]  opcode_t;     // Major opcode, inst[6:2]
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;
    typedef logic [11:0] imm_i_t;      // inst[31:20]
    typedef logic [19:0] imm_u_t;      // inst[31:12]
    typedef logic [3:0]  cause_t;

    localparam opcode_t OPC_LUI    = 5'b01101;
    localparam opcode_t OPC_OP_IMM = 5'b00100;
    localparam opcode_t OPC_OP     = 5'b01100;

    localparam funct7_t FUNCT7_BASE   = 7'b0000000;
    localparam funct7_t FUNCT7_ALT    = 7'b0100000;  // SUB, SRA
    localparam funct7_t FUNCT7_MULDIV = 7'b0000001;

    localparam cause_t CAUSE_ILLEGAL_INSTR = 4'd2;

endpackage

`default_nettype wire

//--- verification/exec_int_vectors.svh
`ifndef EXEC_INT_VECTORS_SVH
`define EXEC_INT_VECTORS_SVH

    typedef struct packed {
        exec_issue_t issue;
        xlen_t       value;
        logic        exc;
    } vec_entry_t;

    vec_entry_t vec_table[$];

    task automatic add_vec(input opcode_t opc, input funct3_t f3, input funct7_t f7,
                           input xlen_t rs1, input xlen_t rs2, input imm_i_t imm_i,
                           input imm_u_t imm_u, input xlen_t value, input logic exc);
        vec_entry_t e;
        e.issue = '{opcode: opc, funct3: f3, funct7: f7, rs1: rs1, rs2: rs2,
                    imm_i: imm_i, imm_u: imm_u};
        e.value = value;
        e.exc   = exc;
        vec_table.push_back(e);
    endtask

    task automatic load_vectors();
        // opcode, funct3, funct7, rs1, rs2, imm_i, imm_u, expected value, exception
        add_vec(OPC_LUI,    3'd0, 7'h00, 64'd0, 64'd0, 12'h000, 20'h12345, 64'h1234_5000, 1'b0);
        add_vec(OPC_LUI,    3'd0, 7'h00, 64'd0, 64'd0, 12'h000, 20'h80000, ~64'h7fff_ffff, 1'b0);
        add_vec(OPC_OP_IMM, 3'd0, 7'h00, 64'd10, 64'd0, 12'hfff, 20'h0, 64'd9, 1'b0);
        add_vec(OPC_OP_IMM, 3'd0, 7'h00, 64'd0, 64'd0, 12'h800, 20'h0, ~64'h7ff, 1'b0);
        add_vec(OPC_OP_IMM, 3'd2, 7'h00, ~64'd4, 64'd0, 12'hffe, 20'h0, 64'd1, 1'b0);
        add_vec(OPC_OP_IMM, 3'd3, 7'h00, 64'd5, 64'd0, 12'hfff, 20'h0, 64'd1, 1'b0);
        add_vec(OPC_OP_IMM, 3'd3, 7'h00, ~64'd0, 64'd0, 12'hfff, 20'h0, 64'd0, 1'b0);
        add_vec(OPC_OP_IMM, 3'd4, 7'h00, 64'hff, 64'd0, 12'hfff, 20'h0, ~64'hff, 1'b0);
        add_vec(OPC_OP_IMM, 3'd6, 7'h00, 64'h1000, 64'd0, 12'h0f0, 20'h0, 64'h10f0, 1'b0);
        add_vec(OPC_OP_IMM, 3'd7, 7'h00, 64'h9abc_def0, 64'd0, 12'h0ff, 20'h0, 64'hf0, 1'b0);
        add_vec(OPC_OP_IMM, 3'd1, 7'h00, 64'd1, 64'd0, 12'h03f, 20'h0, 64'd1 << 63, 1'b0);
        add_vec(OPC_OP_IMM, 3'd5, 7'h00, 64'd1 << 63, 64'd0, 12'h004, 20'h0, 64'd1 << 59, 1'b0);
        add_vec(OPC_OP_IMM, 3'd5, 7'h00, 64'd1 << 63, 64'd0, 12'h404, 20'h0, ~64'd0 << 59, 1'b0);
        add_vec(OPC_OP,     3'd0, 7'h00, ~64'd0, 64'd1, 12'h0, 20'h0, 64'd0, 1'b0);
        add_vec(OPC_OP,     3'd0, 7'h20, 64'd3, 64'd5, 12'h0, 20'h0, ~64'd1, 1'b0);
        add_vec(OPC_OP,     3'd1, 7'h00, 64'd3, 64'h44, 12'h0, 20'h0, 64'h30, 1'b0);
        add_vec(OPC_OP,     3'd2, 7'h00, 64'd1, 64'd1 << 63, 12'h0, 20'h0, 64'd0, 1'b0);
        add_vec(OPC_OP,     3'd3, 7'h00, 64'd1, 64'd1 << 63, 12'h0, 20'h0, 64'd1, 1'b0);
        add_vec(OPC_OP,     3'd4, 7'h00, 64'hf0f0, ~64'd0, 12'h0, 20'h0, ~64'hf0f0, 1'b0);
        add_vec(OPC_OP,     3'd5, 7'h00, ~64'd0 << 60, 64'd124, 12'h0, 20'h0, 64'hf, 1'b0);
        add_vec(OPC_OP,     3'd5, 7'h20, ~64'd0 << 60, 64'd124, 12'h0, 20'h0, ~64'd0, 1'b0);
        add_vec(OPC_OP,     3'd6, 7'h00, 64'h0f0f, 64'hf0f0, 12'h0, 20'h0, 64'hffff, 1'b0);
        add_vec(OPC_OP,     3'd7, 7'h00, 64'hff00, 64'h0ff0, 12'h0, 20'h0, 64'h0f00, 1'b0);
        add_vec(OPC_OP,     3'd0, 7'h01, 64'd3, 64'd5, 12'h0, 20'h0, 64'd15, 1'b0);
        add_vec(OPC_OP,     3'd0, 7'h01, ~64'd0, 64'd5, 12'h0, 20'h0, ~64'd4, 1'b0);
        add_vec(OPC_OP,     3'd1, 7'h01, ~64'd0, ~64'd0, 12'h0, 20'h0, 64'd0, 1'b0);
        add_vec(OPC_OP,     3'd2, 7'h01, ~64'd0, ~64'd0, 12'h0, 20'h0, ~64'd0, 1'b0);
        add_vec(OPC_OP,     3'd3, 7'h01, ~64'd0, ~64'd0, 12'h0, 20'h0, ~64'd1, 1'b0);
        // Illegal encodings, value must come back as zero
        add_vec(5'h1f,      3'd0, 7'h00, 64'd7, 64'd7, 12'h0, 20'h0, 64'd0, 1'b1);
        add_vec(OPC_OP_IMM, 3'd1, 7'h00, 64'd1, 64'd0, 12'h041, 20'h0, 64'd0, 1'b1);
        add_vec(OPC_OP,     3'd4, 7'h20, 64'd9, 64'd3, 12'h0, 20'h0, 64'd0, 1'b1);
        add_vec(OPC_OP,     3'd4, 7'h01, 64'd9, 64'd3, 12'h0, 20'h0, 64'd0, 1'b1);
        add_vec(OPC_OP,     3'd0, 7'h02, 64'd9, 64'd3, 12'h0, 20'h0, 64'd0, 1'b1);
    endtask

`endif

//--- verification/exec_int_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_int_tb
    import riscv_isa_pkg::*;
    import exec_pkg::*;
();

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;
    localparam int RAND_COUNT   = 64;  // Multiply and ADD pairs
    localparam int MARGIN       = 64;

    typedef struct packed {
        logic [31:0] due;
        xlen_t       value;
        logic        exc;
    } expect_t;

    logic         clk = 1'b0;
    logic         rst;
    logic         i_valid;
    exec_issue_t  i_issue;
    logic         o_valid;
    exec_result_t o_result;

    logic [31:0]  cycle = '0;  // Rising edges seen so far
    logic [31:0]  lfsr;
    expect_t      exp_q[$];

    `include "exec_int_vectors.svh"

    exec_int_unit dut (
        .clk      (clk),
        .rst      (rst),
        .i_valid  (i_valid),
        .i_issue  (i_issue),
        .o_valid  (o_valid),
        .o_result (o_result)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    task automatic check_value(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s is 0x%h, expected 0x%h", $time, name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_word(output xlen_t w);
        for (int i = 0; i < XLEN; i++) begin
            lfsr = lfsr_next(lfsr);
            w[i] = lfsr[0];
        end
    endtask

    // Full 128-bit product of the extended operands
    function automatic xlen_t mul_model(input funct3_t f3, input xlen_t a, input xlen_t b);
        logic              a_neg;
        logic              b_neg;
        logic [2*XLEN-1:0] prod;
        a_neg = (f3 == 3'd1 || f3 == 3'd2) && a[XLEN-1];  // rs1 signed for MULH, MULHSU
        b_neg = (f3 == 3'd1) && b[XLEN-1];
        prod  = {{XLEN{a_neg}}, a} * {{XLEN{b_neg}}, b};
        return (f3 == 3'd0) ? prod[XLEN-1:0] : prod[2*XLEN-1:XLEN];
    endfunction

    task automatic issue(input exec_issue_t iss, input xlen_t value, input logic exc);
        @(posedge clk);
        #1;
        i_valid = 1'b1;
        i_issue = iss;
        exp_q.push_back('{due: cycle + 2, value: value, exc: exc});
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            i_valid = 1'b0;
            i_issue = '0;
        end
    endtask

    // Output must match the queue head on exactly its due cycle
    always @(negedge clk) begin : monitor
        expect_t head;
        logic    due_now;
        due_now = exp_q.size() != 0 && exp_q[0].due == cycle;
        check_value("o_valid", xlen_t'(o_valid), xlen_t'(due_now));
        if (o_valid) begin
            head = exp_q.pop_front();
            check_value("o_result.exception", xlen_t'(o_result.exception), xlen_t'(head.exc));
            if (head.exc) begin
                check_value("o_result.cause", xlen_t'(o_result.cause),
                            xlen_t'(CAUSE_ILLEGAL_INSTR));
            end
            check_value("o_result.value", o_result.value, head.value);
        end else begin
            check_value("o_result.exception", xlen_t'(o_result.exception), 64'd0);
        end
    end

    initial begin
        exec_issue_t iss;
        xlen_t       a;
        xlen_t       b;
        rst     = 1'b1;
        i_valid = 1'b1;  // Illegal op held during reset must never come out
        i_issue = '0;
        lfsr    = 32'h9622_b10e;
        load_vectors();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst     = 1'b0;
        i_valid = 1'b0;
        idle(4);
        foreach (vec_table[i]) begin
            issue(vec_table[i].issue, vec_table[i].value, vec_table[i].exc);
        end
        idle(3);
        for (int i = 0; i < RAND_COUNT; i++) begin  // No idle cycle between ops
            random_word(a);
            random_word(b);
            iss        = '0;
            iss.opcode = OPC_OP;
            iss.funct7 = FUNCT7_MULDIV;
            iss.funct3 = funct3_t'(i % 4);
            iss.rs1    = a;
            iss.rs2    = b;
            issue(iss, mul_model(iss.funct3, a, b), 1'b0);
            iss.funct7 = FUNCT7_BASE;
            iss.funct3 = 3'd0;
            issue(iss, a + b, 1'b0);
        end
        idle(1);
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        idle(2);
        $display("TESTBENCH PASSED");
        $finish;
    end

    initial begin : watchdog
        int unsigned limit_ns;
        #1;
        limit_ns = (vec_table.size() + 2 * RAND_COUNT + RESET_CYCLES + MARGIN) * CLK_PERIOD;
        #(limit_ns);
        $display("Simulation timed out after %0d ns with results still outstanding", limit_ns);
        $display("TESTBENCH FAILED");
        $fatal(1);
    end

endmodule

`default_nettype wire
